// ==== run.sh ====
#!/bin/sh
# Compile and run the register file testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module tb_register_file -f src.f \
  -o tb_register_file > build.log 2>&1 || { cat build.log; echo "Build error"; exit 1; }
./obj_dir/tb_register_file > sim.log 2>&1
cat sim.log
# Pass only when the testbench printed its pass line
grep -qx "Simulation completed successfully" sim.log && exit 0 || exit 1

// ==== sim/msp430_register_file_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module msp430_register_file_sva (
  input logic                         mclk_r1,
  input logic                         puc_rst,
  input logic                         reg_sr_clr,
  input msp430_arch_pkg::reg_bank_t   regs,
  input msp430_arch_pkg::flags_t      status,
  input msp430_regfile_pkg::sr_ctrl_t sr_ctrl
);

  // --------------------------------------------------------------------------
  // Port properties of the register file
  // --------------------------------------------------------------------------

  // DCO control is not writable on this mask set
  scg0_never_set : assert property (@(posedge mclk_r1) disable iff (puc_rst)
    !sr_ctrl.scg0)
    else $error("sr_ctrl.scg0 went high");

  // Stack pointer stays word aligned
  sp_aligned : assert property (@(posedge mclk_r1) disable iff (puc_rst)
    !regs[msp430_arch_pkg::SP_IDX][0])
    else $error("R1 bit 0 is set");

  // Interrupt entry empties R2, cpuoff left out as a new write may raise it early
  sr_clr_empties_sr : assert property (@(posedge mclk_r1) disable iff (puc_rst)
    reg_sr_clr |=> (regs[msp430_arch_pkg::SR_IDX] == '0) && (status == '0) &&
                   !sr_ctrl.gie && !sr_ctrl.oscoff && !sr_ctrl.scg1)
    else $error("R2 not cleared after reg_sr_clr");

endmodule

bind msp430_register_file msp430_register_file_sva sva_i (
  .mclk_r1    (mclk_r1),
  .puc_rst    (puc_rst),
  .reg_sr_clr (reg_sr_clr),
  .regs       (regs),
  .status     (status),
  .sr_ctrl    (sr_ctrl)
);

`default_nettype wire

// ==== sim/tb_register_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_register_file;

  localparam int unsigned NUM_CYCLES = 4000;       // Random stimulus items
  localparam int unsigned MAX_CYCLES = 5000;       // Watchdog limit
  localparam time         DRIVE_DLY  = 2ns;        // Input skew after the edge

  logic                         mclk_r1;
  logic                         puc_rst;
  msp430_arch_pkg::word_t       pc;
  msp430_arch_pkg::word_t       reg_dest_val;
  msp430_arch_pkg::word_t       reg_sp_val;
  msp430_arch_pkg::reg_sel_t    inst_src;
  msp430_arch_pkg::reg_sel_t    inst_dest;
  msp430_arch_pkg::flags_t      alu_stat;
  msp430_arch_pkg::flags_t      alu_stat_wr;
  logic                         inst_bw;
  logic                         reg_dest_wr;
  logic                         reg_pc_call;
  logic                         reg_sp_wr;
  logic                         reg_sr_wr;
  logic                         reg_sr_clr;
  logic                         reg_incr;
  msp430_arch_pkg::reg_bank_t   regs;
  msp430_arch_pkg::word_t       reg_src;
  msp430_arch_pkg::word_t       reg_dest;
  msp430_arch_pkg::word_t       pc_sw;
  logic                         pc_sw_wr;
  msp430_arch_pkg::flags_t      status;
  msp430_regfile_pkg::sr_ctrl_t sr_ctrl;

  msp430_arch_pkg::reg_bank_t   mdl;               // Reference bank with R0 mirroring pc
  msp430_arch_pkg::reg_bank_t   mdl_nxt;           // Bank after the coming edge
  logic [31:0]                  rng_state;
  int unsigned                  check_count;
  int unsigned                  error_count;
  logic                         run_done = 1'b0;

  msp430_register_file dut_i (
    .mclk_r1, .puc_rst, .pc, .reg_dest_val, .reg_sp_val, .inst_src, .inst_dest,
    .alu_stat, .alu_stat_wr, .inst_bw, .reg_dest_wr, .reg_pc_call, .reg_sp_wr,
    .reg_sr_wr, .reg_sr_clr, .reg_incr, .regs, .reg_src, .reg_dest, .pc_sw,
    .pc_sw_wr, .status, .sr_ctrl
  );

  initial begin
    mclk_r1 = 1'b0;
    forever #10 mclk_r1 = ~mclk_r1;                // 20 ns period
  end

  // --------------------------------------------------------------------------
  // Random source and decode helpers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // One-hot selection or empty about one time in sixteen
  function automatic msp430_arch_pkg::reg_sel_t rand_sel();
    logic [31:0] r;
    r = lcg_next();
    if (r[19:16] == 4'd0) return '0;
    return 16'h0001 << r[23:20];                   // Upper LCG bits have long periods
  endfunction

  function automatic msp430_arch_pkg::word_t read_sel(input msp430_arch_pkg::reg_bank_t bank,
                                                      input msp430_arch_pkg::reg_sel_t  sel);
    for (int unsigned i = 0; i < msp430_arch_pkg::NUM_REGS; i++) begin
      if (sel[i]) return bank[i];
    end
    return '0;                                     // Nothing selected
  endfunction

  // Interrupt entry forces R2 onto the source port
  function automatic msp430_arch_pkg::reg_sel_t eff_src();
    return reg_sr_clr ? (16'h0001 << msp430_arch_pkg::SR_IDX) : inst_src;
  endfunction

  function automatic msp430_arch_pkg::word_t wr_value();
    return inst_bw ? {8'h00, reg_dest_val[7:0]} : reg_dest_val;
  endfunction

  function automatic logic sr_written();
    return (reg_dest_wr & inst_dest[msp430_arch_pkg::SR_IDX]) | reg_sr_wr;
  endfunction

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------
  task automatic check_word(input string what, input msp430_arch_pkg::word_t got,
                            input msp430_arch_pkg::word_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR @ %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bank(input string what, input msp430_arch_pkg::reg_bank_t got,
                            input msp430_arch_pkg::reg_bank_t exp);
    check_count++;
    for (int unsigned i = 0; i < msp430_arch_pkg::NUM_REGS; i++) begin
      if (got[i] !== exp[i]) begin                 // One line per bad register
        error_count++;
        $display("ERROR @ %0t: %s R%0d is %h, expected %h", $time, what, i, got[i], exp[i]);
      end
    end
  endtask

  task automatic check_flags(input string what, input msp430_arch_pkg::flags_t got,
                             input msp430_arch_pkg::flags_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR @ %0t: %s {V,N,Z,C} is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_ctrl(input string what, input msp430_regfile_pkg::sr_ctrl_t got,
                            input msp430_regfile_pkg::sr_ctrl_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR @ %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR @ %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // --------------------------------------------------------------------------
  // Stimulus and reference model
  // --------------------------------------------------------------------------
  task automatic drive_random();
    logic [31:0] r;
    inst_src     = rand_sel();
    inst_dest    = rand_sel();
    r            = lcg_next();
    reg_dest_val = r[31:16];
    r            = lcg_next();
    reg_sp_val   = r[31:16];
    r            = lcg_next();
    pc           = r[31:16];
    r            = lcg_next();
    inst_bw      = r[31];
    reg_dest_wr  = r[30];
    reg_incr     = r[29];
    reg_sp_wr    = r[28] & r[27];                  // About one in four
    reg_sr_wr    = r[26] & r[25] & r[24];          // About one in eight
    reg_pc_call  = r[23] & r[22] & r[21];
    reg_sr_clr   = r[20] & r[19] & r[18] & r[17];  // Rare interrupt entry
    alu_stat     = r[16:13];
    alu_stat_wr  = r[12:9] & r[8:5];
  endtask

  // Combinational outputs against the bank as it stands
  task automatic check_outputs();
    msp430_arch_pkg::word_t       wv;
    msp430_arch_pkg::word_t       sr;
    msp430_regfile_pkg::sr_ctrl_t exp_ctrl;
    wv = wr_value();
    sr = mdl[msp430_arch_pkg::SR_IDX];
    exp_ctrl.cpuoff = sr[msp430_arch_pkg::SR_CPUOFF] |
                      (sr_written() & wv[msp430_arch_pkg::SR_CPUOFF]);   // Early halt
    exp_ctrl.gie    = sr[msp430_arch_pkg::SR_GIE];
    exp_ctrl.oscoff = sr[msp430_arch_pkg::SR_OSCOFF];
    exp_ctrl.scg0   = 1'b0;                        // DCO control not writable
    exp_ctrl.scg1   = sr[msp430_arch_pkg::SR_SCG1];
    check_bank("regs", regs, mdl);
    check_word("reg_src", reg_src, read_sel(mdl, eff_src()));
    check_word("reg_dest", reg_dest, read_sel(mdl, inst_dest));
    check_word("pc_sw", pc_sw, wv);
    check_bit("pc_sw_wr", pc_sw_wr,
              (reg_dest_wr & inst_dest[msp430_arch_pkg::PC_IDX]) | reg_pc_call);
    check_flags("status", status, {sr[msp430_arch_pkg::SR_V], sr[msp430_arch_pkg::SR_N],
                                   sr[msp430_arch_pkg::SR_Z], sr[msp430_arch_pkg::SR_C]});
    check_ctrl("sr_ctrl", sr_ctrl, exp_ctrl);
  endtask

  task automatic update_model();
    msp430_arch_pkg::reg_sel_t sel;
    msp430_arch_pkg::word_t    wv;
    msp430_arch_pkg::word_t    inc;
    msp430_arch_pkg::word_t    sr_new;
    sel = eff_src();
    wv  = wr_value();
    inc = read_sel(mdl, sel) + ((inst_bw && !sel[msp430_arch_pkg::SP_IDX]) ?
                                msp430_arch_pkg::INCR_BYTE : msp430_arch_pkg::INCR_WORD);
    mdl_nxt = mdl;
    // R3 to R15 with write over increment and no @R3+
    for (int unsigned i = msp430_arch_pkg::CG_IDX; i < msp430_arch_pkg::NUM_REGS; i++) begin
      if (reg_dest_wr && inst_dest[i]) mdl_nxt[i] = wv;
      else if (reg_incr && sel[i] && i != msp430_arch_pkg::CG_IDX) mdl_nxt[i] = inc;
    end
    // R1 priority and word alignment
    if (reg_dest_wr && inst_dest[msp430_arch_pkg::SP_IDX])
      mdl_nxt[msp430_arch_pkg::SP_IDX] = wv & msp430_arch_pkg::SP_ALIGN_MASK;
    else if (reg_sp_wr)
      mdl_nxt[msp430_arch_pkg::SP_IDX] = reg_sp_val & msp430_arch_pkg::SP_ALIGN_MASK;
    else if (reg_incr && sel[msp430_arch_pkg::SP_IDX])
      mdl_nxt[msp430_arch_pkg::SP_IDX] = inc & msp430_arch_pkg::SP_ALIGN_MASK;
    // R2 takes ALU flags over software, then the mask, then the clear
    sr_new = sr_written() ? wv : mdl[msp430_arch_pkg::SR_IDX];
    if (alu_stat_wr[0]) sr_new[msp430_arch_pkg::SR_C] = alu_stat[0];
    if (alu_stat_wr[1]) sr_new[msp430_arch_pkg::SR_Z] = alu_stat[1];
    if (alu_stat_wr[2]) sr_new[msp430_arch_pkg::SR_N] = alu_stat[2];
    if (alu_stat_wr[3]) sr_new[msp430_arch_pkg::SR_V] = alu_stat[3];
    sr_new = sr_new & msp430_arch_pkg::SR_MASK;
    if (reg_sr_clr) sr_new = '0;
    mdl_nxt[msp430_arch_pkg::SR_IDX] = sr_new;
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    rng_state   = 32'h9ef28a2a;
    check_count = 0;
    error_count = 0;
    puc_rst     = 1'b1;
    {pc, reg_dest_val, reg_sp_val, inst_src, inst_dest} = '0;
    {alu_stat, alu_stat_wr} = '0;
    {inst_bw, reg_dest_wr, reg_pc_call, reg_sp_wr, reg_sr_wr, reg_sr_clr, reg_incr} = '0;
    mdl     = '0;
    mdl_nxt = '0;

    repeat (5) @(posedge mclk_r1);                 // Reset held 5 cycles
    #(DRIVE_DLY);
    puc_rst = 1'b0;
    @(negedge mclk_r1);
    check_outputs();                               // Cleared bank with R0 equal to pc
    update_model();

    for (int unsigned cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      @(posedge mclk_r1);
      #(DRIVE_DLY);
      mdl = mdl_nxt;                               // State after this edge
      drive_random();
      mdl[msp430_arch_pkg::PC_IDX] = pc;
      @(negedge mclk_r1);                          // Inputs settled
      check_outputs();
      update_model();
    end

    run_done = 1'b1;
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin : watchdog
    int unsigned n;
    n = 0;
    while (!run_done && n < MAX_CYCLES) begin
      @(posedge mclk_r1);
      n++;
    end
    if (!run_done) begin
      $display("Timeout: stimulus did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== src.f ====
verilog/msp430_arch_pkg.sv
verilog/msp430_regfile_pkg.sv
verilog/msp430_write_path.sv
verilog/msp430_stack_pointer.sv
verilog/msp430_status_reg.sv
verilog/msp430_gp_regs.sv
verilog/msp430_read_mux.sv
verilog/msp430_register_file.sv
sim/msp430_register_file_sva.sv
sim/tb_register_file.sv

// ==== verilog/msp430_arch_pkg.sv ====
`default_nettype none

package msp430_arch_pkg;

  // --------------------------------------------------------------------------
  // Register file geometry
  // --------------------------------------------------------------------------
  localparam int unsigned NUM_REGS = 16;      // R0 to R15

  typedef logic [15:0] word_t;                // Register or data word
  typedef logic [15:0] reg_sel_t;             // One-hot, bit n selects Rn
  typedef logic [3:0]  flags_t;               // {V,N,Z,C}

  // Whole bank, slot n holds Rn
  typedef word_t [NUM_REGS-1:0] reg_bank_t;

  // Special register slots
  localparam int unsigned PC_IDX = 0;         // Program counter
  localparam int unsigned SP_IDX = 1;         // Stack pointer
  localparam int unsigned SR_IDX = 2;         // Status register
  localparam int unsigned CG_IDX = 3;         // Constant generator, no @R3+

  // --------------------------------------------------------------------------
  // Status register layout
  // --------------------------------------------------------------------------
  localparam int unsigned SR_C      = 0;
  localparam int unsigned SR_Z      = 1;
  localparam int unsigned SR_N      = 2;
  localparam int unsigned SR_GIE    = 3;
  localparam int unsigned SR_CPUOFF = 4;      // CPU halted
  localparam int unsigned SR_OSCOFF = 5;      // LFXT1 off
  localparam int unsigned SR_SCG0   = 6;      // DCO off, not writable here
  localparam int unsigned SR_SCG1   = 7;      // SMCLK off
  localparam int unsigned SR_V      = 8;

  // Writable bits of R2
  // Flags, GIE, CPUOFF, OSCOFF and SCG1 only
  localparam word_t SR_MASK = 16'h01bf;

  // --------------------------------------------------------------------------
  // Stack pointer and auto-increment
  // --------------------------------------------------------------------------
  localparam word_t SP_ALIGN_MASK = 16'hfffe; // SP stays word aligned
  localparam word_t INCR_BYTE     = 16'd1;    // @Rn+ byte step
  localparam word_t INCR_WORD     = 16'd2;    // @Rn+ word step, and always on R1

endpackage

`default_nettype wire

// ==== verilog/msp430_gp_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module msp430_gp_regs (
  input  logic                        mclk_r1,
  input  logic                        puc_rst,
  input  msp430_regfile_pkg::wr_bus_t wr_bus,
  output wire msp430_arch_pkg::reg_bank_t gp    // Slots 0 to 2 unused
);

  // --------------------------------------------------------------------------
  // R3 and R4 to R15
  // --------------------------------------------------------------------------
  for (genvar i = 0; i < msp430_arch_pkg::NUM_REGS; i++) begin : g_reg
    if (i < msp430_arch_pkg::CG_IDX) begin : g_unused
      assign gp[i] = '0;    // PC, SP and SR live elsewhere
    end else begin : g_store
      logic                   inc_en;
      msp430_arch_pkg::word_t r_q;

      // No @R3+, that mode yields the constant -1
      assign inc_en = wr_bus.inc_sel[i] & (i != msp430_arch_pkg::CG_IDX);

      always_ff @(posedge mclk_r1 or posedge puc_rst) begin
        if (puc_rst) begin
          r_q <= '0;
        end else if (wr_bus.wr_sel[i]) begin
          r_q <= wr_bus.wr_val;     // Write beats increment
        end else if (inc_en) begin
          r_q <= wr_bus.inc_val;
        end
      end

      assign gp[i] = r_q;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/msp430_read_mux.sv ====
`timescale 1ns/100ps
`default_nettype none

module msp430_read_mux (
  input  msp430_arch_pkg::reg_bank_t regs,
  input  msp430_arch_pkg::reg_sel_t  src_sel,    // One-hot or empty
  input  msp430_arch_pkg::reg_sel_t  dest_sel,   // One-hot or empty
  output msp430_arch_pkg::word_t     reg_src,
  output msp430_arch_pkg::word_t     reg_dest
);

  // --------------------------------------------------------------------------
  // AND-OR read ports
  // --------------------------------------------------------------------------
  // No priority encoder, the selections are one-hot
  // An empty selection reads 0
  always_comb begin
    reg_src  = '0;
    reg_dest = '0;
    for (int i = 0; i < msp430_arch_pkg::NUM_REGS; i++) begin
      reg_src  |= regs[i] & {16{src_sel[i]}};
      reg_dest |= regs[i] & {16{dest_sel[i]}};
    end
  end

endmodule

`default_nettype wire

// ==== verilog/msp430_regfile_pkg.sv ====
`default_nettype none

package msp430_regfile_pkg;

  // --------------------------------------------------------------------------
  // Write request, fanned out from the write path to every register block
  // --------------------------------------------------------------------------
  typedef struct packed {
    msp430_arch_pkg::reg_sel_t wr_sel;   // Destination strobes, gated by reg_dest_wr
    msp430_arch_pkg::reg_sel_t inc_sel;  // Increment strobes, gated by reg_incr
    msp430_arch_pkg::word_t    wr_val;   // Write data, byte accesses zero extended
    msp430_arch_pkg::word_t    inc_val;  // Selected source plus step
  } wr_bus_t;

  // --------------------------------------------------------------------------
  // Low-power and interrupt controls taken from R2
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic cpuoff;   // Halt the CPU, asserted early on the write
    logic gie;      // Global interrupt enable
    logic oscoff;   // LFXT1 off
    logic scg0;     // DCO off, always 0 on this mask set
    logic scg1;     // SMCLK off
  } sr_ctrl_t;

  // Field layout reminder
  //   wr_bus_t  is 64 bits, wr_sel on top
  //   sr_ctrl_t is 5 bits, cpuoff on top
  // Both travel between the register blocks as plain packed vectors

endpackage

`default_nettype wire

// ==== verilog/msp430_register_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module msp430_register_file (
  input  logic                         mclk_r1,
  input  logic                         puc_rst,
  input  msp430_arch_pkg::word_t       pc,            // Program counter, shown as R0
  input  msp430_arch_pkg::word_t       reg_dest_val,
  input  msp430_arch_pkg::word_t       reg_sp_val,
  input  msp430_arch_pkg::reg_sel_t    inst_src,
  input  msp430_arch_pkg::reg_sel_t    inst_dest,
  input  msp430_arch_pkg::flags_t      alu_stat,
  input  msp430_arch_pkg::flags_t      alu_stat_wr,
  input  logic                         inst_bw,
  input  logic                         reg_dest_wr,
  input  logic                         reg_pc_call,
  input  logic                         reg_sp_wr,
  input  logic                         reg_sr_wr,
  input  logic                         reg_sr_clr,
  input  logic                         reg_incr,
  output msp430_arch_pkg::reg_bank_t   regs,
  output msp430_arch_pkg::word_t       reg_src,
  output msp430_arch_pkg::word_t       reg_dest,
  output msp430_arch_pkg::word_t       pc_sw,
  output logic                         pc_sw_wr,
  output msp430_arch_pkg::flags_t      status,
  output msp430_regfile_pkg::sr_ctrl_t sr_ctrl
);

  msp430_arch_pkg::reg_sel_t   src_sel;   // After interrupt override
  msp430_regfile_pkg::wr_bus_t wr_bus;
  msp430_arch_pkg::word_t      sp;
  msp430_arch_pkg::word_t      sr;
  msp430_arch_pkg::reg_bank_t  gp;        // R3 to R15 valid

  // --------------------------------------------------------------------------
  // Write side
  // --------------------------------------------------------------------------
  msp430_write_path u_write_path (
    .inst_src, .inst_dest, .reg_sr_clr, .inst_bw, .reg_dest_wr, .reg_incr,
    .reg_pc_call, .reg_dest_val, .reg_src, .src_sel, .wr_bus, .pc_sw, .pc_sw_wr
  );

  msp430_stack_pointer u_stack_pointer (
    .mclk_r1, .puc_rst, .wr_bus, .reg_sp_val, .reg_sp_wr, .sp
  );

  msp430_status_reg u_status_reg (
    .mclk_r1, .puc_rst, .wr_bus, .reg_sr_wr, .reg_sr_clr,
    .alu_stat, .alu_stat_wr, .sr, .status, .sr_ctrl
  );

  msp430_gp_regs u_gp_regs (
    .mclk_r1, .puc_rst, .wr_bus, .gp
  );

  // --------------------------------------------------------------------------
  // Bank assembly and read side
  // --------------------------------------------------------------------------
  always_comb begin
    regs                          = gp;
    regs[msp430_arch_pkg::PC_IDX] = pc;
    regs[msp430_arch_pkg::SP_IDX] = sp;
    regs[msp430_arch_pkg::SR_IDX] = sr;
  end

  msp430_read_mux u_read_mux (
    .regs,
    .src_sel,
    .dest_sel (inst_dest),   // Destination port ignores the override
    .reg_src,
    .reg_dest
  );

endmodule

`default_nettype wire

// ==== verilog/msp430_stack_pointer.sv ====
`timescale 1ns/100ps
`default_nettype none

module msp430_stack_pointer (
  input  logic                        mclk_r1,
  input  logic                        puc_rst,
  input  msp430_regfile_pkg::wr_bus_t wr_bus,
  input  msp430_arch_pkg::word_t      reg_sp_val,  // Next SP from the stack path
  input  logic                        reg_sp_wr,   // Stack path write
  output msp430_arch_pkg::word_t      sp
);

  logic sp_wr;    // Destination write to R1
  logic sp_inc;   // @R1+ increment

  assign sp_wr  = wr_bus.wr_sel[msp430_arch_pkg::SP_IDX];
  assign sp_inc = wr_bus.inc_sel[msp430_arch_pkg::SP_IDX];

  // --------------------------------------------------------------------------
  // R1, destination write first, stack path next, increment last
  // --------------------------------------------------------------------------
  always_ff @(posedge mclk_r1 or posedge puc_rst) begin
    if (puc_rst) begin
      sp <= '0;
    end else if (sp_wr) begin
      sp <= wr_bus.wr_val  & msp430_arch_pkg::SP_ALIGN_MASK;
    end else if (reg_sp_wr) begin
      sp <= reg_sp_val     & msp430_arch_pkg::SP_ALIGN_MASK;
    end else if (sp_inc) begin
      sp <= wr_bus.inc_val & msp430_arch_pkg::SP_ALIGN_MASK; // Step is 2, alignment kept
    end
  end

endmodule

`default_nettype wire

// ==== verilog/msp430_status_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

module msp430_status_reg (
  input  logic                         mclk_r1,
  input  logic                         puc_rst,
  input  msp430_regfile_pkg::wr_bus_t  wr_bus,
  input  logic                         reg_sr_wr,    // RETI restores R2
  input  logic                         reg_sr_clr,   // Interrupt entry
  input  msp430_arch_pkg::flags_t      alu_stat,     // ALU flags {V,N,Z,C}
  input  msp430_arch_pkg::flags_t      alu_stat_wr,  // Per-flag ALU update
  output msp430_arch_pkg::word_t       sr,
  output msp430_arch_pkg::flags_t      status,       // {V,N,Z,C}
  output msp430_regfile_pkg::sr_ctrl_t sr_ctrl
);

  logic                   sr_wr;      // Software write to R2
  logic                   flag_c;
  logic                   flag_z;
  logic                   flag_n;
  logic                   flag_v;
  logic [7:3]             ctrl_nxt;   // GIE and low-power bits
  msp430_arch_pkg::word_t sr_nxt;

  // Destination write or RETI
  assign sr_wr = wr_bus.wr_sel[msp430_arch_pkg::SR_IDX] | reg_sr_wr;

  // --------------------------------------------------------------------------
  // Flag merge, ALU over software, otherwise hold
  // --------------------------------------------------------------------------
  assign flag_c = alu_stat_wr[0] ? alu_stat[0] :
                  sr_wr          ? wr_bus.wr_val[msp430_arch_pkg::SR_C] :
                                   sr[msp430_arch_pkg::SR_C];
  assign flag_z = alu_stat_wr[1] ? alu_stat[1] :
                  sr_wr          ? wr_bus.wr_val[msp430_arch_pkg::SR_Z] :
                                   sr[msp430_arch_pkg::SR_Z];
  assign flag_n = alu_stat_wr[2] ? alu_stat[2] :
                  sr_wr          ? wr_bus.wr_val[msp430_arch_pkg::SR_N] :
                                   sr[msp430_arch_pkg::SR_N];
  assign flag_v = alu_stat_wr[3] ? alu_stat[3] :
                  sr_wr          ? wr_bus.wr_val[msp430_arch_pkg::SR_V] :   // V sits at bit 8
                                   sr[msp430_arch_pkg::SR_V];

  assign ctrl_nxt = sr_wr ? wr_bus.wr_val[7:3] : sr[7:3];   // Software only

  // Unwritable bits drop out here, SCG0 included
  assign sr_nxt = {7'h00, flag_v, ctrl_nxt, flag_n, flag_z, flag_c} & msp430_arch_pkg::SR_MASK;

  // --------------------------------------------------------------------------
  // R2
  // --------------------------------------------------------------------------
  always_ff @(posedge mclk_r1 or posedge puc_rst) begin
    if (puc_rst) begin
      sr <= '0;
    end else if (reg_sr_clr) begin
      sr <= '0;             // Interrupt entry wins over everything
    end else begin
      sr <= sr_nxt;
    end
  end

  // --------------------------------------------------------------------------
  // Outputs
  // --------------------------------------------------------------------------
  assign status = {sr[msp430_arch_pkg::SR_V], sr[msp430_arch_pkg::SR_N],
                   sr[msp430_arch_pkg::SR_Z], sr[msp430_arch_pkg::SR_C]};

  always_comb begin
    // Halt one cycle early, the fetch must stop on the writing cycle
    sr_ctrl.cpuoff = sr[msp430_arch_pkg::SR_CPUOFF] |
                     (sr_wr & wr_bus.wr_val[msp430_arch_pkg::SR_CPUOFF] &
                      msp430_arch_pkg::SR_MASK[msp430_arch_pkg::SR_CPUOFF]);
    sr_ctrl.gie    = sr[msp430_arch_pkg::SR_GIE];
    sr_ctrl.oscoff = sr[msp430_arch_pkg::SR_OSCOFF];
    sr_ctrl.scg0   = sr[msp430_arch_pkg::SR_SCG0];     // Masked, reads 0
    sr_ctrl.scg1   = sr[msp430_arch_pkg::SR_SCG1];
  end

endmodule

`default_nettype wire

// ==== verilog/msp430_write_path.sv ====
`timescale 1ns/100ps
`default_nettype none

module msp430_write_path (
  input  msp430_arch_pkg::reg_sel_t  inst_src,     // Decoded source selection
  input  msp430_arch_pkg::reg_sel_t  inst_dest,    // Decoded destination selection
  input  logic                       reg_sr_clr,   // Interrupt entry
  input  logic                       inst_bw,      // Byte access
  input  logic                       reg_dest_wr,  // Write destination
  input  logic                       reg_incr,     // Increment source
  input  logic                       reg_pc_call,  // CALL updates the PC
  input  msp430_arch_pkg::word_t     reg_dest_val, // Destination value
  input  msp430_arch_pkg::word_t     reg_src,      // Source read back from the mux
  output msp430_arch_pkg::reg_sel_t  src_sel,      // Effective source selection
  output msp430_regfile_pkg::wr_bus_t wr_bus,
  output msp430_arch_pkg::word_t     pc_sw,        // PC software value
  output logic                       pc_sw_wr      // PC software write
);

  msp430_arch_pkg::word_t step;   // Auto-increment amount

  // --------------------------------------------------------------------------
  // Source override and increment step
  // --------------------------------------------------------------------------

  // Interrupt entry reads R2 whatever the decoder says
  assign src_sel = reg_sr_clr ? msp430_arch_pkg::reg_sel_t'(1 << msp430_arch_pkg::SR_IDX)
                              : inst_src;

  // R1 steps by 2 even on byte accesses
  assign step = (inst_bw & ~src_sel[msp430_arch_pkg::SP_IDX]) ? msp430_arch_pkg::INCR_BYTE
                                                               : msp430_arch_pkg::INCR_WORD;

  assign wr_bus.inc_val = reg_src + step;

  // --------------------------------------------------------------------------
  // Write data and per-register strobes
  // --------------------------------------------------------------------------
  assign wr_bus.wr_val  = inst_bw ? {8'h00, reg_dest_val[7:0]} : reg_dest_val; // Zero extend

  assign wr_bus.wr_sel  = inst_dest & {16{reg_dest_wr}};
  assign wr_bus.inc_sel = src_sel   & {16{reg_incr}};    // Gated after the override

  // R0 lives outside, only the request leaves here
  assign pc_sw    = wr_bus.wr_val;
  assign pc_sw_wr = wr_bus.wr_sel[msp430_arch_pkg::PC_IDX] | reg_pc_call;

endmodule

`default_nettype wire
